// ==== mem_system.f ====
hw/mem_system_pkg.sv
hw/cache_store.sv
hw/banked_mem.sv
hw/cache_ctrl.sv
hw/mem_system.sv
tb/mem_system_checker.sv
tb/mem_system_tb.sv

// ==== Bender.yml ====
package:
  name: mem_system

sources:
  - hw/mem_system_pkg.sv
  - hw/cache_store.sv
  - hw/banked_mem.sv
  - hw/cache_ctrl.sv
  - hw/mem_system.sv
  - target: test
    files:
      - tb/mem_system_checker.sv
      - tb/mem_system_tb.sv

// ==== tb/mem_system_tb.sv ====
//**************************************************************************
// Testbench for the cached memory subsystem. Generates clock and reset,
// runs directed and random requests and prints one line per test.
// Comparison is done by the checker module.
//**************************************************************************

`timescale 1ns/1ps

module mem_system_tb;

   localparam int CLK_PERIOD        = 40;
   localparam int RESET_CYCLES      = 8;
   localparam int RANDOM_ACCESSES   = 200;
   localparam int NUM_ACCESSES      = 17 + RANDOM_ACCESSES;
   localparam int CYCLES_PER_ACCESS = 40;

   logic                  clk;
   logic                  rst;
   mem_system_pkg::addr_t addr;
   mem_system_pkg::word_t data_in;
   mem_system_pkg::word_t data_out;
   logic                  rd;
   logic                  wr;
   logic                  done;
   logic                  stall;
   logic                  cache_hit;
   logic                  err;

   integer seed;
   int     tests_run;
   int     tests_failed;

   mem_system UUT (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   mem_system_checker chk (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Worst case budget for every access plus reset
   initial begin
      #((NUM_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES) * CLK_PERIOD);
      $display("timeout: a request never finished, run stopped at %0t", $time);
      $display("Some tests failed");
      $finish;
   end

   // Hold the request until done, then release it
   task automatic issue_request(input mem_system_pkg::addr_t a, input mem_system_pkg::word_t d,
                                input logic r, input logic w);
      @(negedge clk);
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      do @(posedge clk); while (done !== 1'b1);
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic report_test(input string name, input int errors_before);
      int new_errors;
      new_errors = chk.error_count - errors_before;
      tests_run++;
      if (new_errors == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, new_errors);
      end
   endtask

   initial begin : stimulus
      int                    errors_before;
      mem_system_pkg::addr_t a;
      logic [31:0]           r;
      seed         = 11;
      tests_run    = 0;
      tests_failed = 0;
      rst          = 1'b1;
      addr         = '0;
      data_in      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      errors_before = chk.error_count;
      repeat (4) @(posedge clk);
      report_test("quiet after reset", errors_before);

      errors_before = chk.error_count;
      issue_request(16'h0000, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h1234, 16'h0000, 1'b1, 1'b0);
      issue_request(16'hfffe, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h8008, 16'h0000, 1'b1, 1'b0);
      report_test("cold reads miss and return zero", errors_before);

      errors_before = chk.error_count;
      issue_request(16'h0310, 16'hc0de, 1'b0, 1'b1);
      issue_request(16'h0310, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0310, 16'h7e57, 1'b0, 1'b1);
      issue_request(16'h0310, 16'h0000, 1'b1, 1'b0);
      report_test("write then read hits", errors_before);

      // Same index 40, tags 1 and 9
      errors_before = chk.error_count;
      issue_request({5'd1, 8'd40, 2'd2, 1'b0}, 16'hbeef, 1'b0, 1'b1);
      issue_request({5'd9, 8'd40, 2'd2, 1'b0}, 16'h1234, 1'b0, 1'b1);
      issue_request({5'd1, 8'd40, 2'd2, 1'b0}, 16'h0000, 1'b1, 1'b0);
      issue_request({5'd9, 8'd40, 2'd2, 1'b0}, 16'h0000, 1'b1, 1'b0);
      report_test("conflict eviction writes back", errors_before);

      errors_before = chk.error_count;
      issue_request(16'h0208, 16'h5a5a, 1'b0, 1'b1);
      issue_request(16'h0209, 16'h0000, 1'b1, 1'b0);
      issue_request(16'h0209, 16'hffff, 1'b0, 1'b1);
      issue_request(16'h0208, 16'h0000, 1'b1, 1'b1);
      issue_request(16'h0208, 16'h0000, 1'b1, 1'b0);
      report_test("bad requests raise err", errors_before);

      // Two tags over eight indexes
      errors_before = chk.error_count;
      for (int i = 0; i < RANDOM_ACCESSES; i++) begin
         r = $random(seed);
         a = {(r[0] ? 5'd6 : 5'd22), 5'b00000, r[3:1], r[5:4], 1'b0};
         issue_request(a, r[31:16], r[6], !r[6]);
      end
      report_test("random reads and writes", errors_before);

      $display("tests run %0d, tests failed %0d, accesses %0d, errors %0d",
               tests_run, tests_failed, chk.access_count, chk.error_count);
      if (tests_failed == 0 && chk.error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== tb/mem_system_checker.sv ====
//**************************************************************************
// Checker for the cached memory subsystem. Watches the top-level ports,
// keeps a word mirror of memory and a tag/valid model per cache line,
// and compares every completed request against them.
//**************************************************************************

`timescale 1ns/1ps

module mem_system_checker (
   input logic                  clk,
   input logic                  rst,
   input mem_system_pkg::addr_t addr,
   input mem_system_pkg::word_t data_in,
   input logic                  rd,
   input logic                  wr,
   input mem_system_pkg::word_t data_out,
   input logic                  done,
   input logic                  stall,
   input logic                  cache_hit,
   input logic                  err
);

   mem_system_pkg::word_t mirror [mem_system_pkg::MEM_WORDS];
   mem_system_pkg::tag_t  model_tag [mem_system_pkg::CACHE_LINES];
   logic                  model_valid [mem_system_pkg::CACHE_LINES];

   int error_count;
   int access_count;

   // Request in flight, captured at acceptance
   logic                  pending;
   mem_system_pkg::addr_t req_addr;
   mem_system_pkg::word_t req_data;
   logic                  req_rd;
   logic                  req_wr;
   int                    wait_cycles;

   // Expected read word and expected hit for an aligned address
   function automatic mem_system_pkg::word_t expected_read(input mem_system_pkg::addr_t a,
                                                           output logic exp_hit);
      exp_hit = model_valid[a[10:3]] && (model_tag[a[10:3]] == a[15:11]);
      return mirror[a[15:1]];
   endfunction

   task automatic flag_error(input string msg);
      $display("Error at %0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic check_completion();
      mem_system_pkg::word_t exp_word;
      logic                  exp_hit;
      access_count++;
      if (stall !== 1'b0) flag_error($sformatf("stall high in done cycle of %h", req_addr));
      if (req_addr[0] || (req_rd && req_wr)) begin
         if (err !== 1'b1 || cache_hit !== 1'b0) begin
            flag_error($sformatf("bad request at %h gave err %b hit %b", req_addr, err, cache_hit));
         end
         if (wait_cycles != 1) flag_error($sformatf("err came after %0d cycles", wait_cycles));
      end else begin
         exp_word = expected_read(req_addr, exp_hit);
         if (err !== 1'b0) flag_error($sformatf("unexpected err for %h", req_addr));
         if (cache_hit !== exp_hit) begin
            flag_error($sformatf("cache_hit %b for %h, expected %b", cache_hit, req_addr, exp_hit));
         end
         if (exp_hit && wait_cycles != 1) begin
            flag_error($sformatf("hit on %h took %0d cycles", req_addr, wait_cycles));
         end
         if (!exp_hit && wait_cycles < 2) flag_error($sformatf("miss on %h too fast", req_addr));
         if (req_rd && data_out !== exp_word) begin
            flag_error($sformatf("read %h returned %h, expected %h", req_addr, data_out, exp_word));
         end
         if (req_wr) mirror[req_addr[15:1]] = req_data;
         // Write-allocate, so the line is resident either way
         model_valid[req_addr[10:3]] = 1'b1;
         model_tag[req_addr[10:3]]   = req_addr[15:11];
      end
   endtask

   initial begin
      error_count  = 0;
      access_count = 0;
      pending      = 1'b0;
      for (int i = 0; i < mem_system_pkg::MEM_WORDS; i++) mirror[i] = '0;
      for (int i = 0; i < mem_system_pkg::CACHE_LINES; i++) model_valid[i] = 1'b0;
   end

   always @(posedge clk) begin
      if (rst) begin
         pending = 1'b0;
         for (int i = 0; i < mem_system_pkg::CACHE_LINES; i++) model_valid[i] = 1'b0;
      end else if (pending) begin
         wait_cycles++;
         if (done === 1'b1) begin
            check_completion();
            pending = 1'b0;
         end else if (stall !== 1'b1) begin
            flag_error($sformatf("stall low while %h in progress", req_addr));
         end
      end else begin
         if ({done, stall, cache_hit, err} !== 4'b0000) begin
            flag_error($sformatf("outputs active while idle: %b", {done, stall, cache_hit, err}));
         end
         if (rd === 1'b1 || wr === 1'b1) begin
            pending     = 1'b1;
            req_addr    = addr;
            req_data    = data_in;
            req_rd      = rd;
            req_wr      = wr;
            wait_cycles = 0;
         end
      end
   end

endmodule

// ==== hw/mem_system.sv ====
//**************************************************************************
// Top of the cached data memory subsystem. Ties the controller, the
// cache arrays and the banked memory together and steers the data.
// The processor holds addr, data_in, rd and wr until done.
//**************************************************************************

`timescale 1ns/1ps

module mem_system (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_system_pkg::addr_t addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   // Controller to cache
   logic                      cache_en;
   logic                      comp;
   logic                      cache_write;
   logic                      valid_in;
   logic                      sel_proc_data;
   mem_system_pkg::index_t    cache_index;
   mem_system_pkg::tag_t      cache_tag;
   mem_system_pkg::word_sel_t word_sel;

   // Cache to controller
   mem_system_pkg::tag_t  tag_out;
   logic                  hit;
   logic                  dirty;
   logic                  valid;
   mem_system_pkg::word_t cache_data_out;
   mem_system_pkg::word_t cache_data_in;

   // Memory side
   mem_system_pkg::addr_t mem_addr;
   logic                  mem_rd;
   logic                  mem_wr;
   logic                  mem_stall;
   logic                  sel_mem_out;
   mem_system_pkg::word_t mem_data_out;

   cache_ctrl ctrl0 (
      .clk           (clk),
      .rst           (rst),
      .addr          (addr),
      .rd            (rd),
      .wr            (wr),
      .mem_stall     (mem_stall),
      .tag_in        (tag_out),
      .hit           (hit),
      .dirty         (dirty),
      .valid         (valid),
      .cache_en      (cache_en),
      .cache_index   (cache_index),
      .cache_tag     (cache_tag),
      .word_sel      (word_sel),
      .comp          (comp),
      .cache_write   (cache_write),
      .valid_in      (valid_in),
      .sel_proc_data (sel_proc_data),
      .mem_addr      (mem_addr),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .sel_mem_out   (sel_mem_out),
      .done          (done),
      .stall         (stall),
      .cache_hit     (cache_hit),
      .err           (err)
   );

   // Processor word on a write, memory word on a fill
   assign cache_data_in = sel_proc_data ? data_in : mem_data_out;

   cache_store cache0 (
      .clk      (clk),
      .rst      (rst),
      .enable   (cache_en),
      .comp     (comp),
      .write    (cache_write),
      .valid_in (valid_in),
      .index    (cache_index),
      .tag_in   (cache_tag),
      .word_sel (word_sel),
      .data_in  (cache_data_in),
      .tag_out  (tag_out),
      .data_out (cache_data_out),
      .hit      (hit),
      .dirty    (dirty),
      .valid    (valid)
   );

   // Writebacks always take the cache word
   banked_mem mem0 (
      .clk      (clk),
      .rst      (rst),
      .addr     (mem_addr),
      .data_in  (cache_data_out),
      .rd       (mem_rd),
      .wr       (mem_wr),
      .data_out (mem_data_out),
      .stall    (mem_stall),
      .busy     ()
   );

   assign data_out = sel_mem_out ? mem_data_out : cache_data_out;

endmodule

// ==== hw/cache_ctrl.sv ====
//**************************************************************************
// Cache controller FSM. Checks for a hit, writes back a dirty victim,
// refills the line from banked memory and completes the request.
// Refill fetches the requested word last so it arrives with done.
//**************************************************************************

`timescale 1ns/1ps

module cache_ctrl (
   input  logic                      clk,
   input  logic                      rst,
   input  mem_system_pkg::addr_t     addr,
   input  logic                      rd,
   input  logic                      wr,
   input  logic                      mem_stall,
   input  mem_system_pkg::tag_t      tag_in,
   input  logic                      hit,
   input  logic                      dirty,
   input  logic                      valid,
   output logic                      cache_en,
   output mem_system_pkg::index_t    cache_index,
   output mem_system_pkg::tag_t      cache_tag,
   output mem_system_pkg::word_sel_t word_sel,
   output logic                      comp,
   output logic                      cache_write,
   output logic                      valid_in,
   output logic                      sel_proc_data,
   output mem_system_pkg::addr_t     mem_addr,
   output logic                      mem_rd,
   output logic                      mem_wr,
   output logic                      sel_mem_out,
   output logic                      done,
   output logic                      stall,
   output logic                      cache_hit,
   output logic                      err
);

   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_writeback,
      st_refill,
      st_drain,
      st_complete
   } cache_state_t;

   localparam mem_system_pkg::word_sel_t LAST_WORD =
      mem_system_pkg::word_sel_t'(mem_system_pkg::LINE_WORDS - 1);

   cache_state_t state, next_state;

   mem_system_pkg::tag_t      req_tag;
   mem_system_pkg::index_t    req_index;
   mem_system_pkg::word_sel_t req_word;
   logic                      req_err;

   // Writeback, read issue and fill counters
   mem_system_pkg::word_sel_t wb_cnt;
   mem_system_pkg::word_sel_t rf_cnt;
   mem_system_pkg::word_sel_t fill_cnt;
   mem_system_pkg::word_sel_t rf_word;
   mem_system_pkg::word_sel_t fill_word;

   // One bit per read in flight in the memory pipeline
   logic [mem_system_pkg::MEM_READ_LATENCY-1:0] issue_pipe;
   logic rd_accept;
   logic ret_valid;

   assign req_tag   = addr[15:11];
   assign req_index = addr[10:3];
   assign req_word  = addr[2:1];
   assign req_err   = addr[0] || (rd && wr);

   // Start one past the requested word so it comes back last
   assign rf_word   = mem_system_pkg::word_sel_t'(req_word + rf_cnt + 2'd1);
   assign fill_word = mem_system_pkg::word_sel_t'(req_word + fill_cnt + 2'd1);

   assign rd_accept = mem_rd && !mem_stall;
   assign ret_valid = issue_pipe[mem_system_pkg::MEM_READ_LATENCY-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_idle;
         wb_cnt     <= '0;
         rf_cnt     <= '0;
         fill_cnt   <= '0;
         issue_pipe <= '0;
      end else begin
         state      <= next_state;
         issue_pipe <= {issue_pipe[mem_system_pkg::MEM_READ_LATENCY-2:0], rd_accept};
         // Counters wrap back to zero after the last word
         if ((state == st_writeback) && !mem_stall) begin
            wb_cnt <= wb_cnt + 2'd1;
         end
         if (rd_accept) begin
            rf_cnt <= rf_cnt + 2'd1;
         end
         if (ret_valid) begin
            fill_cnt <= fill_cnt + 2'd1;
         end
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         st_idle:      if (rd || wr) next_state = st_compare;
         st_compare: begin
            if (req_err || hit) begin
               next_state = st_idle;
            end else if (valid && dirty) begin
               next_state = st_writeback;
            end else begin
               next_state = st_refill;
            end
         end
         st_writeback: if (!mem_stall && (wb_cnt == LAST_WORD)) next_state = st_refill;
         st_refill:    if (rd_accept && (rf_cnt == LAST_WORD)) next_state = st_drain;
         // Last read is one cycle from returning
         st_drain:     if (issue_pipe[mem_system_pkg::MEM_READ_LATENCY-2]) next_state = st_complete;
         st_complete:  next_state = st_idle;
         default:      next_state = st_idle;
      endcase
   end

   always_comb begin
      cache_en      = 1'b0;
      cache_index   = req_index;
      cache_tag     = req_tag;
      word_sel      = req_word;
      comp          = 1'b0;
      cache_write   = 1'b0;
      valid_in      = 1'b0;
      sel_proc_data = 1'b0;
      mem_addr      = {req_tag, req_index, rf_word, 1'b0};
      mem_rd        = 1'b0;
      mem_wr        = 1'b0;
      sel_mem_out   = 1'b0;
      done          = 1'b0;
      cache_hit     = 1'b0;
      err           = 1'b0;
      case (state)
         st_compare: begin
            cache_en      = 1'b1;
            comp          = 1'b1;
            sel_proc_data = 1'b1;
            cache_write   = wr && hit && !req_err;
            done          = hit || req_err;
            cache_hit     = hit && !req_err;
            err           = req_err;
         end
         st_writeback: begin
            // Victim address comes from the stored tag
            cache_en = 1'b1;
            word_sel = wb_cnt;
            mem_wr   = 1'b1;
            mem_addr = {tag_in, req_index, wb_cnt, 1'b0};
         end
         st_refill, st_drain: begin
            mem_rd = (state == st_refill);
            if (ret_valid) begin
               cache_en    = 1'b1;
               cache_write = 1'b1;
               valid_in    = 1'b1;
               word_sel    = fill_word;
            end
         end
         st_complete: begin
            cache_en    = 1'b1;
            cache_write = 1'b1;
            done        = 1'b1;
            if (wr) begin
               // Line is valid by now, so this is a hit write
               comp          = 1'b1;
               sel_proc_data = 1'b1;
            end else begin
               valid_in    = 1'b1;
               sel_mem_out = 1'b1;
            end
         end
         default: ;
      endcase
   end

   assign stall = (state != st_idle) && !done;

   assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done held for two cycles");

endmodule

// ==== hw/banked_mem.sv ====
//**************************************************************************
// Four-bank main memory model, interleaved on word address bits 1:0.
// A bank stays busy for a fixed time after each access; an access to
// a busy bank raises stall and is dropped. Reads return after a fixed
// latency through a short pipeline.
//**************************************************************************

`timescale 1ns/1ps

module banked_mem (
   input  logic                       clk,
   input  logic                       rst,
   input  mem_system_pkg::addr_t      addr,
   input  mem_system_pkg::word_t      data_in,
   input  logic                       rd,
   input  logic                       wr,
   output mem_system_pkg::word_t      data_out,
   output logic                       stall,
   output mem_system_pkg::bank_mask_t busy
);

   mem_system_pkg::word_t mem [mem_system_pkg::MEM_WORDS];

   // Per-bank countdown, nonzero means busy
   logic [mem_system_pkg::BUSY_CNT_W-1:0] busy_cnt [$bits(mem_system_pkg::bank_mask_t)];

   // Read data pipeline
   mem_system_pkg::word_t rd_pipe [mem_system_pkg::MEM_READ_LATENCY];

   mem_system_pkg::word_sel_t bank;
   logic [14:0]               word_addr;
   logic                      accept;

   assign word_addr = addr[15:1];
   assign bank      = addr[2:1];

   always_comb begin
      for (int b = 0; b < $bits(mem_system_pkg::bank_mask_t); b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   assign stall  = (rd || wr) && busy[bank];
   assign accept = (rd || wr) && !busy[bank];

   // Storage starts cleared
   initial begin
      for (int i = 0; i < mem_system_pkg::MEM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && wr) begin
         mem[word_addr] <= data_in;
      end
   end

   // Bank timers
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < $bits(mem_system_pkg::bank_mask_t); b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < $bits(mem_system_pkg::bank_mask_t); b++) begin
            if (accept && (bank == b)) begin
               busy_cnt[b] <= mem_system_pkg::BUSY_CNT_W'(mem_system_pkg::BANK_BUSY_CYCLES);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Stage 0 samples the array, later stages just shift
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < mem_system_pkg::MEM_READ_LATENCY; s++) begin
            rd_pipe[s] <= '0;
         end
      end else begin
         rd_pipe[0] <= (accept && rd) ? mem[word_addr] : '0;
         for (int s = 1; s < mem_system_pkg::MEM_READ_LATENCY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
         end
      end
   end

   assign data_out = rd_pipe[mem_system_pkg::MEM_READ_LATENCY-1];

   assert property (@(posedge clk) disable iff (rst) !(rd && wr))
      else $error("memory rd and wr both high");

endmodule

// ==== hw/cache_store.sv ====
//**************************************************************************
// Direct-mapped cache arrays: tag, valid, dirty and line data.
// Lookups are combinational, updates land on the clock edge.
// comp high selects a compare write, comp low a line fill write.
//**************************************************************************

`timescale 1ns/1ps

module cache_store (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      enable,
   input  logic                      comp,
   input  logic                      write,
   input  logic                      valid_in,
   input  mem_system_pkg::index_t    index,
   input  mem_system_pkg::tag_t      tag_in,
   input  mem_system_pkg::word_sel_t word_sel,
   input  mem_system_pkg::word_t     data_in,
   output mem_system_pkg::tag_t      tag_out,
   output mem_system_pkg::word_t     data_out,
   output logic                      hit,
   output logic                      dirty,
   output logic                      valid
);

   // Line state
   mem_system_pkg::tag_t tag_arr [mem_system_pkg::CACHE_LINES];
   logic [mem_system_pkg::CACHE_LINES-1:0] valid_arr;
   logic [mem_system_pkg::CACHE_LINES-1:0] dirty_arr;

   // Word storage, addressed by {index, word_sel}
   mem_system_pkg::word_t data_arr [mem_system_pkg::CACHE_LINES *
                                    mem_system_pkg::LINE_WORDS];

   logic do_write;

   assign do_write = enable && write;

   // Combinational lookup
   assign tag_out  = tag_arr[index];
   assign valid    = valid_arr[index];
   assign dirty    = dirty_arr[index];
   assign data_out = data_arr[{index, word_sel}];
   assign hit      = valid && (tag_out == tag_in);

   // Valid and dirty bits
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (do_write) begin
         if (comp) begin
            dirty_arr[index] <= 1'b1;
         end else begin
            // Fill leaves the line clean
            valid_arr[index] <= valid_in;
            dirty_arr[index] <= 1'b0;
         end
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (do_write) begin
         data_arr[{index, word_sel}] <= data_in;
         if (!comp) begin
            tag_arr[index] <= tag_in;
         end
      end
   end

   // Controller only writes with the store enabled
   assert property (@(posedge clk) disable iff (rst) write |-> enable)
      else $error("cache write with enable low");

   // A compare write may only land on a hit line
   assert property (@(posedge clk) disable iff (rst)
                    (enable && write && comp) |-> hit)
      else $error("compare write without hit");

endmodule

// ==== hw/mem_system_pkg.sv ====
//**************************************************************************
// Shared types and constants for the cached data memory subsystem.
// Address field types follow the split tag | index | word | byte.
// Modules refer to these by scoped name.
//**************************************************************************

package mem_system_pkg;

   // Byte address and data word
   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;

   // Address fields, bits 15:11, 10:3 and 2:1
   typedef logic [4:0] tag_t;
   typedef logic [7:0] index_t;

   // Word within a line, doubles as the bank number
   typedef logic [1:0] word_sel_t;

   // One busy flag per memory bank
   typedef logic [3:0] bank_mask_t;

   // Cache geometry
   localparam int LINE_WORDS  = 4;
   localparam int CACHE_LINES = 256;

   // Main memory size in words
   localparam int MEM_WORDS = 32768;

   // Cycles from an accepted read to valid read data
   localparam int MEM_READ_LATENCY = 2;

   // Cycles a bank refuses new accesses after accepting one
   localparam int BANK_BUSY_CYCLES = 4;

   // Width of the per-bank busy counter
   localparam int BUSY_CNT_W = $clog2(BANK_BUSY_CYCLES + 1);

endpackage
